//--- project.f
+incdir+include
verilog/tr_pkg.sv
verilog/tr_step_if.sv
verilog/parity_bank.sv
verilog/transpose_ctrl.sv
verilog/line_acc.sv
verilog/out_mux.sv
verilog/parity_transposer.sv
test/tb_parity_transposer.sv

//--- run_sim.sh
#!/bin/sh
# build and run the parity transposer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f \
  --top-module tb_parity_transposer -o sim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Finished with no errors"; then
  exit 0
fi
exit 1

//--- test/tb_parity_transposer.sv
/*
  testbench of the parity transpose stage
  random data words and parity blocks, bit order model, compare tasks, watchdog
*/

`timescale 1ns/100ps
`include "tr_macros.svh"

module tb_parity_transposer;

  import tr_pkg::*;

  localparam int NDATA   = 24;
  // block 0 is full size then 1..5 with random rows and 6..8 back to back
  localparam int NBLOCKS = 9;

  logic  iclk;
  logic  ireset;
  logic  iclkena;
  addr_t iwrow;
  addr_t iwdata_col;
  logic  iwrite;
  addr_t iwaddr;
  word_t iwdat;
  logic  ipwrite;
  addr_t ipwaddr;
  logic  iwfull;
  logic  ordy;
  logic  owrite;
  logic  owfull;
  addr_t owaddr;
  word_t owdat;

  // output beats as seen by the monitor
  addr_t got_addr [$];
  word_t got_dat  [$];
  logic  got_full [$];

  int    checks = 0;
  int    errors = 0;
  int    cycles = 0;
  int    limit  = 0;
  int    rlist  [NBLOCKS];

  parity_transposer dut_i (
    .iclk       (iclk),
    .ireset     (ireset),
    .iclkena    (iclkena),
    .iwrow      (iwrow),
    .iwdata_col (iwdata_col),
    .iwrite     (iwrite),
    .iwaddr     (iwaddr),
    .iwdat      (iwdat),
    .ipwrite    (ipwrite),
    .ipwaddr    (ipwaddr),
    .iwfull     (iwfull),
    .ordy       (ordy),
    .owrite     (owrite),
    .owfull     (owfull),
    .owaddr     (owaddr),
    .owdat      (owdat)
  );

  initial begin
    iclk = 1'b0;
    forever #5 iclk = ~iclk;
  end

  //----------------------------------------------------------------------
  // compare tasks
  //----------------------------------------------------------------------

  task automatic check_word(input string name, input word_t exp, input word_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Error %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  //----------------------------------------------------------------------
  // drivers
  //----------------------------------------------------------------------

  // one clock with the enable low about one cycle in four and strobes only when enabled
  task automatic drive_cycle(input logic wr, input logic pwr, input logic full,
                             input addr_t a, input word_t d, input addr_t col,
                             output logic ena);
    @(posedge iclk);
    ena = ($urandom_range(3) != 0);
    iclkena    <= ena;
    iwrite     <= wr && ena;
    ipwrite    <= pwr && ena;
    iwfull     <= full && ena;
    iwaddr     <= a;
    ipwaddr    <= a;
    iwrow      <= a;
    iwdat      <= d;
    iwdata_col <= col;
  endtask

  // repeat until the strobe lands in an enabled cycle
  task automatic issue(input logic wr, input logic pwr, input logic full,
                       input addr_t a, input word_t d, input addr_t col);
    logic ena;
    do begin
      drive_cycle(wr, pwr, full, a, d, col, ena);
    end while (!ena);
  endtask

  task automatic idle_cycle();
    logic ena;
    drive_cycle(1'b0, 1'b0, 1'b0, '0, '0, '0, ena);
  endtask

  task automatic wait_words(input int n);
    while (got_dat.size() < n) begin
      idle_cycle();
    end
    // surplus words would show up here
    repeat (4) idle_cycle();
    if (got_dat.size() != n) begin
      errors++;
      $display("output gave %0d words where %0d were expected", got_dat.size(), n);
    end
  endtask

  task automatic clear_queues();
    got_addr.delete();
    got_dat.delete();
    got_full.delete();
  endtask

  task automatic report_test(input string name, input int err0);
    if (errors == err0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - err0);
    end
  endtask

  //----------------------------------------------------------------------
  // one parity block, rows in, transpose, compare with the model
  //----------------------------------------------------------------------

  task automatic run_block(input string name, input int r);
    word_t rows [2**`ADDR_W];
    addr_t col;
    word_t exp;
    int    j;
    col = addr_t'($urandom);
    for (int i = 0; i < r; i++) begin
      rows[i] = word_t'($urandom);
      issue(1'b0, 1'b1, 1'b0, addr_t'(i), rows[i], col);
    end
    // 2^ADDR_W rows wrap to zero on iwrow
    issue(1'b0, 1'b0, 1'b1, addr_t'(r), '0, col);
    // iwfull is taken at this edge, ordy is settled by the falling edge
    idle_cycle();
    @(negedge iclk);
    check_flag({name, " ordy after iwfull"}, 1'b0, ordy);
    wait_words(r);
    for (int w = 0; w < r; w++) begin
      for (int b = 0; b < `DAT_W; b++) begin
        // parity bit j is row j mod R of column j / R
        j = w * `DAT_W + b;
        exp[b] = rows[j % r][j / r];
      end
      check_word({name, " data"}, exp, got_dat[w]);
      check_addr({name, " addr"}, addr_t'(col + w), got_addr[w]);
      check_flag({name, " owfull"}, (w == r - 1), got_full[w]);
    end
    clear_queues();
  endtask

  //----------------------------------------------------------------------
  // monitor and watchdog
  //----------------------------------------------------------------------

  // outputs hold while disabled, so one beat per enabled edge
  always @(posedge iclk) begin
    if (!ireset && iclkena && owrite) begin
      got_addr.push_back(owaddr);
      got_dat.push_back(owdat);
      got_full.push_back(owfull);
      if (owfull) begin
        check_flag("ordy before owfull", 1'b1, ordy);
      end
    end
  end

  always @(posedge iclk) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout, the DUT did not deliver all words within %0d cycles", limit);
      $display("Finished with errors");
      $finish;
    end
  end

  //----------------------------------------------------------------------
  // test sequence
  //----------------------------------------------------------------------

  initial begin
    int    sum;
    int    err0;
    addr_t adr [NDATA];
    word_t dat [NDATA];
    void'($urandom(32'h300c));
    ireset     = 1'b1;
    iclkena    = 1'b1;
    iwrite     = 1'b0;
    ipwrite    = 1'b0;
    iwfull     = 1'b0;
    iwrow      = '0;
    iwdata_col = '0;
    iwaddr     = '0;
    iwdat      = '0;
    ipwaddr    = '0;
    rlist[0] = 2**`ADDR_W;
    for (int i = 1; i < NBLOCKS; i++) begin
      rlist[i] = `TR_DAT_W * $urandom_range(15, 1);
    end
    // steps, row writes and slack per block over an enable rate of 3/4
    sum = NDATA + 24;
    foreach (rlist[i]) begin
      sum += (rlist[i] / `TR_DAT_W) * `DAT_W + rlist[i] + 20;
    end
    limit = 2 * sum * 4 / 3;
    repeat (4) @(posedge iclk);
    ireset <= 1'b0;
    check_flag("ordy after reset", 1'b1, ordy);

    err0 = errors;
    for (int i = 0; i < NDATA; i++) begin
      adr[i] = addr_t'($urandom);
      dat[i] = word_t'($urandom);
      issue(1'b1, 1'b0, 1'b0, adr[i], dat[i], '0);
    end
    wait_words(NDATA);
    for (int i = 0; i < NDATA; i++) begin
      check_word("pass_through data", dat[i], got_dat[i]);
      check_addr("pass_through addr", adr[i], got_addr[i]);
      check_flag("pass_through owfull", 1'b0, got_full[i]);
    end
    clear_queues();
    report_test("pass_through", err0);

    err0 = errors;
    run_block("full_block", rlist[0]);
    report_test("full_block", err0);

    err0 = errors;
    for (int i = 1; i < 6; i++) begin
      run_block("row_counts", rlist[i]);
      repeat ($urandom_range(5)) idle_cycle();
    end
    report_test("row_counts", err0);

    err0 = errors;
    for (int i = 6; i < NBLOCKS; i++) begin
      run_block("back_to_back", rlist[i]);
    end
    report_test("back_to_back", err0);

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- verilog/parity_transposer.sv
/*
  parity transpose stage top
  step bundle, banks, controller, accumulator and output mux
*/

`timescale 1ns/100ps

module parity_transposer (
  input  logic           iclk,
  input  logic           ireset,
  input  logic           iclkena,
  input  tr_pkg::addr_t  iwrow,
  input  tr_pkg::addr_t  iwdata_col,
  input  logic           iwrite,
  input  tr_pkg::addr_t  iwaddr,
  input  tr_pkg::word_t  iwdat,
  input  logic           ipwrite,
  input  tr_pkg::addr_t  ipwaddr,
  input  logic           iwfull,
  output logic           ordy,
  output logic           owrite,
  output logic           owfull,
  output tr_pkg::addr_t  owaddr,
  output tr_pkg::word_t  owdat
);

  import tr_pkg::*;

  // read steps, controller to banks
  tr_step_if step ();

  // banks to accumulator, two cycles after the step
  logic  bits_val;
  bits_t bits;
  logic  bits_word_end;
  logic  bits_last;

  // accumulator to output
  logic  acc_write;
  word_t acc_dat;
  logic  acc_last;

  //----------------------------------------------------------------------
  // instances
  //----------------------------------------------------------------------

  transpose_ctrl ctrl_i (
    .iclk          (iclk),
    .ireset        (ireset),
    .iclkena       (iclkena),
    .iwfull        (iwfull),
    .iwrow         (iwrow),
    .ordy          (ordy),
    .step          (step.ctrl)
  );

  parity_bank bank_i (
    .iclk          (iclk),
    .ireset        (ireset),
    .iclkena       (iclkena),
    .ipwrite       (ipwrite),
    .ipwaddr       (ipwaddr),
    .iwdat         (iwdat),
    .step          (step.bank),
    .bits_val      (bits_val),
    .bits          (bits),
    .bits_word_end (bits_word_end),
    .bits_last     (bits_last)
  );

  line_acc acc_i (
    .iclk          (iclk),
    .ireset        (ireset),
    .iclkena       (iclkena),
    .bits_val      (bits_val),
    .bits          (bits),
    .bits_word_end (bits_word_end),
    .bits_last     (bits_last),
    .acc_write     (acc_write),
    .acc_dat       (acc_dat),
    .acc_last      (acc_last)
  );

  out_mux mux_i (
    .iclk          (iclk),
    .ireset        (ireset),
    .iclkena       (iclkena),
    .iwrite        (iwrite),
    .ipwrite       (ipwrite),
    .iwaddr        (iwaddr),
    .iwdat         (iwdat),
    .iwdata_col    (iwdata_col),
    .acc_write     (acc_write),
    .acc_dat       (acc_dat),
    .acc_last      (acc_last),
    .owrite        (owrite),
    .owfull        (owfull),
    .owaddr        (owaddr),
    .owdat         (owdat)
  );

endmodule

//--- verilog/out_mux.sv
/*
  output side
  merges data and parity words, parity addressing, block end strobe
*/

`timescale 1ns/100ps

module out_mux (
  input  logic           iclk,
  input  logic           ireset,
  input  logic           iclkena,
  input  logic           iwrite,
  input  logic           ipwrite,
  input  tr_pkg::addr_t  iwaddr,
  input  tr_pkg::word_t  iwdat,
  input  tr_pkg::addr_t  iwdata_col,
  input  logic           acc_write,
  input  tr_pkg::word_t  acc_dat,
  input  logic           acc_last,
  output logic           owrite,
  output logic           owfull,
  output tr_pkg::addr_t  owaddr,
  output tr_pkg::word_t  owdat
);

  import tr_pkg::*;

  // address of the next parity word
  addr_t paddr;

  //----------------------------------------------------------------------
  // strobes
  //----------------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      owrite <= 1'b0;
      owfull <= 1'b0;
      paddr  <= '0;
    end else if (iclkena) begin
      owrite <= iwrite || acc_write;
      owfull <= acc_write && acc_last;
      // base follows the parity row writes, steps per parity word
      if (ipwrite) begin
        paddr <= iwdata_col;
      end else if (acc_write) begin
        paddr <= paddr + 1'b1;
      end
    end
  end

  //----------------------------------------------------------------------
  // address and data
  //----------------------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      if (iwrite) begin
        // systematic word passes through unchanged
        owaddr <= iwaddr;
        owdat  <= iwdat;
      end else if (acc_write) begin
        owaddr <= paddr;
        owdat  <= acc_dat;
      end
    end
  end

  // data words and parity words share one output
  a_no_clash : assert property (
    @(posedge iclk) disable iff (ireset)
    iclkena |-> !(iwrite && acc_write)
  ) else $error("data word during parity readout");

endmodule

//--- verilog/line_acc.sv
/*
  line accumulator
  packs column bits into words, low end first, tags the last word
*/

`timescale 1ns/100ps
`include "tr_macros.svh"

module line_acc (
  input  logic           iclk,
  input  logic           ireset,
  input  logic           iclkena,
  input  logic           bits_val,
  input  tr_pkg::bits_t  bits,
  input  logic           bits_word_end,
  input  logic           bits_last,
  output logic           acc_write,
  output tr_pkg::word_t  acc_dat,
  output logic           acc_last
);

  import tr_pkg::*;

  localparam int STEPS   = `DAT_W / `TR_DAT_W;
  localparam int STEPS_W = $clog2(STEPS);

  // shifts right, so the first bits end at the low end
  word_t              sreg;
  // valid steps since the last word end
  logic [STEPS_W-1:0] cnt;

  always_ff @(posedge iclk) begin
    if (iclkena && bits_val) begin
      sreg <= {bits, sreg[`DAT_W-1:`TR_DAT_W]};
    end
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      acc_write <= 1'b0;
      acc_last  <= 1'b0;
      cnt       <= '0;
    end else if (iclkena) begin
      acc_write <= bits_val && bits_word_end;
      acc_last  <= bits_val && bits_word_end && bits_last;
      if (bits_val) begin
        cnt <= bits_word_end ? '0 : cnt + 1'b1;
      end
    end
  end

  // word is complete in the cycle after its word end step
  assign acc_dat = sreg;

  // word end only after a full word of steps
  a_word_len : assert property (
    @(posedge iclk) disable iff (ireset)
    (iclkena && bits_val) |-> (bits_word_end == (cnt == STEPS_W'(STEPS - 1)))
  ) else $error("word end out of step");

endmodule

//--- verilog/transpose_ctrl.sv
/*
  transpose controller
  idle/read FSM, column and row group walk, word end and last flags
*/

`timescale 1ns/100ps
`include "tr_macros.svh"

module transpose_ctrl (
  input  logic           iclk,
  input  logic           ireset,
  input  logic           iclkena,
  input  logic           iwfull,
  input  tr_pkg::addr_t  iwrow,
  output logic           ordy,
  tr_step_if.ctrl        step
);

  import tr_pkg::*;

  localparam int LOG2_TR = $clog2(`TR_DAT_W);
  // steps that fill one output word
  localparam int STEPS   = `DAT_W / `TR_DAT_W;
  localparam int STEPS_W = $clog2(STEPS);

  tr_state_e          state;

  // last row group index, R/TR_DAT_W - 1
  maddr_t             grp_last;
  maddr_t             grp;
  sel_t               col;
  // step position inside the current output word
  logic [STEPS_W-1:0] wcnt;

  logic               grp_end;
  logic               col_end;

  assign grp_end = (grp == grp_last);
  assign col_end = (col == sel_t'(`DAT_W - 1));

  //----------------------------------------------------------------------
  // FSM and counters
  //----------------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state    <= ST_IDLE;
      grp_last <= '0;
      grp      <= '0;
      col      <= '0;
      wcnt     <= '0;
    end else if (iclkena) begin
      case (state)
        ST_IDLE: begin
          if (iwfull) begin
            state    <= ST_READ;
            // R of zero wraps to the full 2^ADDR_W rows
            grp_last <= iwrow[`ADDR_W-1:LOG2_TR] - 1'b1;
            grp      <= '0;
            col      <= '0;
            wcnt     <= '0;
          end
        end
        ST_READ: begin
          wcnt <= wcnt + 1'b1;
          // inner loop row group, outer loop column
          if (grp_end) begin
            grp <= '0;
            col <= col + 1'b1;
            if (col_end) begin
              state <= ST_IDLE;
            end
          end else begin
            grp <= grp + 1'b1;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  //----------------------------------------------------------------------
  // step outputs
  //----------------------------------------------------------------------

  assign ordy          = (state == ST_IDLE);

  assign step.val      = (state == ST_READ);
  assign step.raddr    = grp;
  assign step.sel      = col;
  assign step.word_end = (wcnt == STEPS_W'(STEPS - 1));
  assign step.last     = grp_end && col_end;

  // a new block only once the previous one has been read out
  a_full_rdy : assert property (
    @(posedge iclk) disable iff (ireset)
    (iclkena && iwfull) |-> ordy
  ) else $error("iwfull while busy");

  // whole row groups only, zero stands for 2^ADDR_W
  a_row_mult : assert property (
    @(posedge iclk) disable iff (ireset)
    (iclkena && iwfull) |-> (iwrow[LOG2_TR-1:0] == '0)
  ) else $error("row count is not a multiple of the bank count");

endmodule

//--- verilog/parity_bank.sv
/*
  parity row banks
  row write decoding, one cycle read, registered column bit select
*/

`timescale 1ns/100ps
`include "tr_macros.svh"

module parity_bank (
  input  logic           iclk,
  input  logic           ireset,
  input  logic           iclkena,
  input  logic           ipwrite,
  input  tr_pkg::addr_t  ipwaddr,
  input  tr_pkg::word_t  iwdat,
  tr_step_if.bank        step,
  output logic           bits_val,
  output tr_pkg::bits_t  bits,
  output logic           bits_word_end,
  output logic           bits_last
);

  import tr_pkg::*;

  localparam int LOG2_TR = $clog2(`TR_DAT_W);

  // row r lives in bank r mod TR_DAT_W at address r / TR_DAT_W
  word_t  mem [`TR_DAT_W][2**`MEM_ADDR_W];

  // raw rows and matching select of the first stage
  word_t  rdat [`TR_DAT_W];
  sel_t   sel_d;

  // step flags in the first delay stage
  logic   val_d;
  logic   word_end_d;
  logic   last_d;

  //----------------------------------------------------------------------
  // banks and bit select
  //----------------------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      for (int k = 0; k < `TR_DAT_W; k++) begin
        // low address bits pick the bank
        if (ipwrite && (ipwaddr[LOG2_TR-1:0] == k[LOG2_TR-1:0])) begin
          mem[k][ipwaddr[`ADDR_W-1:LOG2_TR]] <= iwdat;
        end
        // same row group read from all banks
        rdat[k] <= mem[k][step.raddr];
        // one bit per bank picked by column
        bits[k] <= rdat[k][sel_d];
      end
      sel_d <= step.sel;
    end
  end

  //----------------------------------------------------------------------
  // two stage flag delay to line up with bits
  //----------------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      val_d         <= 1'b0;
      word_end_d    <= 1'b0;
      last_d        <= 1'b0;
      bits_val      <= 1'b0;
      bits_word_end <= 1'b0;
      bits_last     <= 1'b0;
    end else if (iclkena) begin
      val_d         <= step.val;
      word_end_d    <= step.word_end;
      last_d        <= step.last;
      bits_val      <= val_d;
      bits_word_end <= word_end_d;
      bits_last     <= last_d;
    end
  end

  // bank rows stay fixed while a block is read out
  a_no_write_read : assert property (
    @(posedge iclk) disable iff (ireset)
    (iclkena && step.val) |-> !ipwrite
  ) else $error("parity row write during readout");

endmodule

//--- verilog/tr_step_if.sv
/*
  read step bundle, controller to parity banks
*/

`timescale 1ns/100ps

interface tr_step_if;

  import tr_pkg::*;

  // one read step per cycle while val is high
  logic   val;
  // row group to read from every bank
  maddr_t raddr;
  // column to pick from the read rows
  sel_t   sel;
  // this step completes an output word
  logic   word_end;
  // final step of the block
  logic   last;

  modport ctrl (
    output val,
    output raddr,
    output sel,
    output word_end,
    output last
  );

  modport bank (
    input val,
    input raddr,
    input sel,
    input word_end,
    input last
  );

endinterface

//--- verilog/tr_pkg.sv
/*
  shared types of the parity transpose stage
  word, address, column select, bank bits and controller states
*/

package tr_pkg;

  `include "tr_macros.svh"

  // one data or parity word
  typedef logic [`DAT_W-1:0]      word_t;

  // output address, also the row count R
  typedef logic [`ADDR_W-1:0]     addr_t;

  // column index inside a parity row
  typedef logic [`SEL_W-1:0]      sel_t;

  // one bit per bank, bit k from bank k
  typedef logic [`TR_DAT_W-1:0]   bits_t;

  // bank address == row group index
  typedef logic [`MEM_ADDR_W-1:0] maddr_t;

  // controller states
  typedef enum logic {
    ST_IDLE,
    ST_READ
  } tr_state_e;

endpackage

//--- include/tr_macros.svh
/*
  width parameters of the parity transpose stage
  word, address, bank count and derived bank address width
*/

`ifndef TR_MACROS_SVH
`define TR_MACROS_SVH

// data and parity word width
`define DAT_W       16

// output address and row count width
`define ADDR_W      6

// number of parity banks, rows read per step
`define TR_DAT_W    4

// column index width, enough for DAT_W columns
`define SEL_W       4

// per bank address, one entry per row group
`define MEM_ADDR_W  (`ADDR_W - $clog2(`TR_DAT_W))

`endif
